//--- logic/xbar_mon_pkg.sv
package xbar_mon_pkg;

	// Cache lines are 16 bytes, so the low nibble is not carried
	localparam int ADDR_LSB = 4;

	// Return bank field width for the default of four banks
	// Wider crossbars need a wider field
	localparam int RTN_BANK_W = 2;

	typedef logic [31:ADDR_LSB] line_addr_t;

	// Only OP_READ among the request opcodes is tracked
	typedef enum logic [2:0] {
		OP_READ       = 3'd0,
		OP_WRITE      = 3'd1,
		OP_WRITE_PART = 3'd2,
		OP_FLUSH      = 3'd3,
		OP_INVALIDATE = 3'd4,
		OP_CLEAN      = 3'd5
	} op_e;

	// Observed request handshake
	typedef struct packed {
		logic       valid;
		logic       accepted;
		op_e        op;
		line_addr_t addr;
	} req_mon_t;

	// Observed return handshake
	typedef struct packed {
		logic                  valid;
		logic [RTN_BANK_W-1:0] bank;
	} rtn_mon_t;

	// Sticky per-channel error flags
	typedef struct packed {
		logic req_overflow;
		logic rtn_underflow;
		logic rtn_unmatched;
		logic rob_overflow;
		logic rob_underflow;
	} chan_err_t;

endpackage

//--- logic/bank_counter_array.sv
module bank_counter_array #(
	parameter int NUM_BANKS = 4,
	parameter int CNT_W     = 10
) (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic [NUM_BANKS-1:0]                inc_i,
	input  logic [NUM_BANKS-1:0]                dec_i,
	output logic [NUM_BANKS-1:0][CNT_W-1:0]     count_o,
	output logic                                overflow_o,
	output logic                                underflow_o
);

	logic [NUM_BANKS-1:0][CNT_W-1:0] count_q;
	logic [NUM_BANKS-1:0][CNT_W-1:0] count_nxt;
	logic [NUM_BANKS-1:0]            up;
	logic [NUM_BANKS-1:0]            down;
	logic [NUM_BANKS-1:0]            at_max;
	logic [NUM_BANKS-1:0]            at_zero;
	logic [NUM_BANKS-1:0]            ovf_hit;
	logic [NUM_BANKS-1:0]            unf_hit;
	logic                            overflow_q;
	logic                            underflow_q;

	// Same-cycle inc and dec on a bank cancel out
	assign up   = inc_i & ~dec_i;
	assign down = dec_i & ~inc_i;

	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			at_max[b]  = (count_q[b] == {CNT_W{1'b1}});
			at_zero[b] = (count_q[b] == '0);
		end
	end

	// Blocked wraps
	assign ovf_hit = up & at_max;
	assign unf_hit = down & at_zero;

	always_comb begin
		count_nxt = count_q;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (up[b] && !at_max[b]) begin
				count_nxt[b] = count_q[b] + 1'b1;
			end
			else if (down[b] && !at_zero[b]) begin
				count_nxt[b] = count_q[b] - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			count_q <= '0;
		end
		else begin
			count_q <= count_nxt;
		end
	end

	// Held until reset
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			overflow_q  <= 1'b0;
			underflow_q <= 1'b0;
		end
		else begin
			overflow_q  <= overflow_q | (|ovf_hit);
			underflow_q <= underflow_q | (|unf_hit);
		end
	end

	assign count_o     = count_q;
	assign overflow_o  = overflow_q;
	assign underflow_o = underflow_q;

	// Callers decode a single bank per event
	a_inc_onehot: assert property (
		@(posedge clk_i) disable iff (rst_i)
		$onehot0(inc_i)
	) else $error("more than one bank incremented in one cycle");

	a_dec_onehot: assert property (
		@(posedge clk_i) disable iff (rst_i)
		$onehot0(dec_i)
	) else $error("more than one bank decremented in one cycle");

endmodule

//--- logic/chan_monitor.sv
module chan_monitor #(
	parameter int NUM_BANKS = 4,
	parameter int BANK_LSB  = 8,
	parameter int CNT_W     = 10
) (
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  xbar_mon_pkg::req_mon_t          req_i,
	input  xbar_mon_pkg::rtn_mon_t          rtn_i,
	input  logic [NUM_BANKS-1:0]            rob_push_i,
	input  logic [NUM_BANKS-1:0]            rob_pop_i,
	output logic [NUM_BANKS-1:0][CNT_W-1:0] outstanding_o,
	output logic [NUM_BANKS-1:0][CNT_W-1:0] occupancy_o,
	output xbar_mon_pkg::chan_err_t         err_o
);

	import xbar_mon_pkg::*;

	localparam int BANK_W = $clog2(NUM_BANKS);

	logic                 rd_kickoff;
	logic                 rtn_kickoff;
	logic [BANK_W-1:0]    req_bank;
	logic [NUM_BANKS-1:0] rd_inc;
	logic [NUM_BANKS-1:0] rtn_dec;
	logic [NUM_BANKS-1:0] out_zero;
	logic                 unmatched_hit;
	logic                 rtn_unmatched_q;
	logic                 req_overflow;
	logic                 rtn_underflow;
	logic                 rob_overflow;
	logic                 rob_underflow;

	// Each channel qualifies on its own opcode
	assign rd_kickoff  = req_i.valid & req_i.accepted & (req_i.op == OP_READ);
	assign rtn_kickoff = rtn_i.valid;

	// Bank select from the line address
	assign req_bank = req_i.addr[BANK_LSB +: BANK_W];

	always_comb begin
		rd_inc  = '0;
		rtn_dec = '0;
		if (rd_kickoff) begin
			rd_inc[req_bank] = 1'b1;
		end
		if (rtn_kickoff) begin
			rtn_dec[rtn_i.bank] = 1'b1;
		end
	end

	bank_counter_array #(
		.NUM_BANKS (NUM_BANKS),
		.CNT_W     (CNT_W)
	) u_outstanding (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.inc_i       (rd_inc),
		.dec_i       (rtn_dec),
		.count_o     (outstanding_o),
		.overflow_o  (req_overflow),
		.underflow_o (rtn_underflow)
	);

	bank_counter_array #(
		.NUM_BANKS (NUM_BANKS),
		.CNT_W     (CNT_W)
	) u_rob (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.inc_i       (rob_push_i),
		.dec_i       (rob_pop_i),
		.count_o     (occupancy_o),
		.overflow_o  (rob_overflow),
		.underflow_o (rob_underflow)
	);

	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			out_zero[b] = (outstanding_o[b] == '0);
		end
	end

	// A read to the same bank in the same cycle pairs with the return
	assign unmatched_hit = |(rtn_dec & ~rd_inc & out_zero);

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			rtn_unmatched_q <= 1'b0;
		end
		else begin
			rtn_unmatched_q <= rtn_unmatched_q | unmatched_hit;
		end
	end

	assign err_o = '{
		req_overflow:  req_overflow,
		rtn_underflow: rtn_underflow,
		rtn_unmatched: rtn_unmatched_q,
		rob_overflow:  rob_overflow,
		rob_underflow: rob_underflow
	};

	// Unaccepted requests leave the outstanding counts alone
	a_no_count_unaccepted: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(req_i.valid && !req_i.accepted && !rtn_i.valid) |=> $stable(outstanding_o)
	) else $error("outstanding count moved on a request that was not accepted");

endmodule

//--- logic/xbar_read_monitor.sv
module xbar_read_monitor #(
	parameter int NUM_CH    = 3,
	parameter int NUM_BANKS = 4,
	parameter int BANK_LSB  = 8,
	parameter int CNT_W     = 10
) (
	input  logic                                        clk_i,
	input  logic                                        rst_i,
	input  xbar_mon_pkg::req_mon_t  [NUM_CH-1:0]        req_i,
	input  xbar_mon_pkg::rtn_mon_t  [NUM_CH-1:0]        rtn_i,
	input  logic [NUM_CH-1:0][NUM_BANKS-1:0]            rob_push_i,
	input  logic [NUM_CH-1:0][NUM_BANKS-1:0]            rob_pop_i,
	output logic [NUM_CH-1:0][NUM_BANKS-1:0][CNT_W-1:0] outstanding_o,
	output logic [NUM_CH-1:0][NUM_BANKS-1:0][CNT_W-1:0] occupancy_o,
	output xbar_mon_pkg::chan_err_t [NUM_CH-1:0]        err_o
);

	// One independent monitor per crossbar channel
	for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
		chan_monitor #(
			.NUM_BANKS (NUM_BANKS),
			.BANK_LSB  (BANK_LSB),
			.CNT_W     (CNT_W)
		) u_chan (
			.clk_i         (clk_i),
			.rst_i         (rst_i),
			.req_i         (req_i[ch]),
			.rtn_i         (rtn_i[ch]),
			.rob_push_i    (rob_push_i[ch]),
			.rob_pop_i     (rob_pop_i[ch]),
			.outstanding_o (outstanding_o[ch]),
			.occupancy_o   (occupancy_o[ch]),
			.err_o         (err_o[ch])
		);
	end

endmodule

//--- test/xbar_read_monitor_checker.sv
module xbar_read_monitor_checker #(
	parameter int NUM_CH    = 3,
	parameter int NUM_BANKS = 4,
	parameter int CNT_W     = 10,
	parameter int NAME_W    = 256,
	parameter int EXP_W     = 16 + 2 * CNT_W + $bits(xbar_mon_pkg::chan_err_t)
) (
	input  logic                                        clk_i,
	input  logic                                        expect_valid_i,
	input  logic [NAME_W-1:0]                           expect_name_i,
	input  logic [EXP_W-1:0]                            expect_data_i,
	input  logic [NUM_CH-1:0][NUM_BANKS-1:0][CNT_W-1:0] outstanding_i,
	input  logic [NUM_CH-1:0][NUM_BANKS-1:0][CNT_W-1:0] occupancy_i,
	input  xbar_mon_pkg::chan_err_t [NUM_CH-1:0]        err_i,
	output logic                                        done_o,
	output int                                          pass_count_o,
	output int                                          fail_count_o
);

	import xbar_mon_pkg::*;

	// One expect record as packed by the testbench
	typedef struct packed {
		logic [7:0]       ch;
		logic [7:0]       bank;
		logic [CNT_W-1:0] outstanding;
		logic [CNT_W-1:0] occupancy;
		chan_err_t        err;
	} expect_t;

	logic done_q     = 1'b0;
	int   pass_count = 0;
	int   fail_count = 0;

	task automatic compare_record();
		expect_t          exp;
		logic [CNT_W-1:0] act_out;
		logic [CNT_W-1:0] act_occ;
		chan_err_t        act_err;
		exp = expect_data_i;
		if (int'(exp.ch) >= NUM_CH || int'(exp.bank) >= NUM_BANKS) begin
			$display("%0s: expect record names channel %0d bank %0d, which the monitor lacks",
				expect_name_i, exp.ch, exp.bank);
			fail_count++;
			return;
		end
		act_out = outstanding_i[exp.ch][exp.bank];
		act_occ = occupancy_i[exp.ch][exp.bank];
		act_err = err_i[exp.ch];
		if (act_out !== exp.outstanding || act_occ !== exp.occupancy || act_err !== exp.err) begin
			$display("FAILED %0s expected out=%0d occ=%0d err=%b actual out=%0d occ=%0d err=%b",
				expect_name_i, exp.outstanding, exp.occupancy, exp.err,
				act_out, act_occ, act_err);
			fail_count++;
		end
		else begin
			$display("ok     %0s ch%0d bank%0d out=%0d occ=%0d err=%b",
				expect_name_i, exp.ch, exp.bank, act_out, act_occ, act_err);
			pass_count++;
		end
	endtask

	// Sampled on the falling edge while inputs and counts are stable
	always @(negedge clk_i) begin
		done_q <= expect_valid_i;
		if (expect_valid_i) begin
			compare_record();
		end
	end

	assign done_o       = done_q;
	assign pass_count_o = pass_count;
	assign fail_count_o = fail_count;

endmodule

//--- test/xbar_read_monitor_tb.sv
module xbar_read_monitor_tb;

	import xbar_mon_pkg::*;

	localparam int NUM_CH     = 3;
	localparam int NUM_BANKS  = 4;
	localparam int CNT_W      = 10;
	localparam int NAME_W     = 8 * 32;
	localparam int EXP_W      = 16 + 2 * CNT_W + $bits(chan_err_t);
	localparam int ACK_LIMIT  = 20;
	localparam int MAX_CYCLES = 4096;

	logic                                        clk;
	logic                                        rst;
	req_mon_t [NUM_CH-1:0]                       req;
	rtn_mon_t [NUM_CH-1:0]                       rtn;
	logic [NUM_CH-1:0][NUM_BANKS-1:0]            rob_push;
	logic [NUM_CH-1:0][NUM_BANKS-1:0]            rob_pop;
	logic [NUM_CH-1:0][NUM_BANKS-1:0][CNT_W-1:0] outstanding;
	logic [NUM_CH-1:0][NUM_BANKS-1:0][CNT_W-1:0] occupancy;
	chan_err_t [NUM_CH-1:0]                      err;
	logic                                        expect_valid;
	logic [NAME_W-1:0]                           expect_name;
	logic [EXP_W-1:0]                            expect_data;
	logic                                        chk_done;
	int                                          pass_count;
	int                                          fail_count;
	bit                                          run_aborted;

	xbar_read_monitor UUT (
		.clk_i         (clk),
		.rst_i         (rst),
		.req_i         (req),
		.rtn_i         (rtn),
		.rob_push_i    (rob_push),
		.rob_pop_i     (rob_pop),
		.outstanding_o (outstanding),
		.occupancy_o   (occupancy),
		.err_o         (err)
	);

	xbar_read_monitor_checker #(
		.NUM_CH    (NUM_CH),
		.NUM_BANKS (NUM_BANKS),
		.CNT_W     (CNT_W),
		.NAME_W    (NAME_W)
	) u_chk (
		.clk_i          (clk),
		.expect_valid_i (expect_valid),
		.expect_name_i  (expect_name),
		.expect_data_i  (expect_data),
		.outstanding_i  (outstanding),
		.occupancy_i    (occupancy),
		.err_i          (err),
		.done_o         (chk_done),
		.pass_count_o   (pass_count),
		.fail_count_o   (fail_count)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	function automatic logic [NAME_W-1:0] name_bits(input string s);
		logic [NAME_W-1:0] bits;
		bits = '0;
		for (int i = 0; i < s.len() && i < NAME_W / 8; i++) begin
			bits = {bits[NAME_W-9:0], s[i]};
		end
		return bits;
	endfunction

	task automatic drive_idle();
		req      = '0;
		rtn      = '0;
		rob_push = '0;
		rob_pop  = '0;
	endtask

	task automatic reset_dut(input int cycles);
		drive_idle();
		rst = 1'b1;
		repeat (cycles) begin
			@(posedge clk);
			#5;
		end
		rst = 1'b0;
	endtask

	task automatic drive_record(input int fd);
		string                name;
		int                   cycles;
		int                   code;
		int                   rv;
		int                   ra;
		int                   op;
		int                   tv;
		int                   tbank;
		logic [31:0]          addr;
		logic [NUM_BANKS-1:0] push;
		logic [NUM_BANKS-1:0] pop;
		code = $fscanf(fd, "%s %d", name, cycles);
		if (code != 2 || cycles < 1 || cycles > MAX_CYCLES) begin
			$display("Drive record %s is malformed or has a bad cycle count", name);
			run_aborted = 1'b1;
			return;
		end
		for (int ch = 0; ch < NUM_CH; ch++) begin
			code = $fscanf(fd, "%d %d %d %h %d %d %h %h",
				rv, ra, op, addr, tv, tbank, push, pop);
			if (code != 8) begin
				$display("Drive record %s has a malformed group for channel %0d", name, ch);
				run_aborted = 1'b1;
				return;
			end
			req[ch].valid    = rv[0];
			req[ch].accepted = ra[0];
			req[ch].op       = op_e'(op[2:0]);
			req[ch].addr     = addr[31:ADDR_LSB];
			rtn[ch].valid    = tv[0];
			rtn[ch].bank     = tbank[RTN_BANK_W-1:0];
			rob_push[ch]     = push;
			rob_pop[ch]      = pop;
		end
		repeat (cycles) begin
			@(posedge clk);
			#5;
		end
	endtask

	task automatic check_record(input int fd);
		string            name;
		int               code;
		int               waited;
		logic [7:0]       ch;
		logic [7:0]       bank;
		logic [CNT_W-1:0] out_exp;
		logic [CNT_W-1:0] occ_exp;
		logic [4:0]       err_exp;
		code = $fscanf(fd, "%s %d %d %d %d %b", name, ch, bank, out_exp, occ_exp, err_exp);
		if (code != 6) begin
			$display("Expect record %s is malformed", name);
			run_aborted = 1'b1;
			return;
		end
		// One idle cycle so the last event has settled
		drive_idle();
		@(posedge clk);
		#5;
		expect_name  = name_bits(name);
		expect_data  = {ch, bank, out_exp, occ_exp, err_exp};
		expect_valid = 1'b1;
		waited = 0;
		while (chk_done !== 1'b1 && waited < ACK_LIMIT) begin
			@(posedge clk);
			#5;
			waited++;
		end
		expect_valid = 1'b0;
		if (chk_done !== 1'b1) begin
			$display("Timed out waiting for the checker to take expect record %s", name);
			run_aborted = 1'b1;
		end
	endtask

	task automatic run_patterns();
		int                 fd;
		int                 code;
		int                 cycles;
		string              tok;
		string              name;
		logic [8*160-1:0]   rest;
		fd = $fopen("test/xbar_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file test/xbar_patterns.txt");
			run_aborted = 1'b1;
			return;
		end
		code = $fscanf(fd, "%s", tok);
		while (code == 1 && !run_aborted) begin
			if (tok == "#") begin
				code = $fgets(rest, fd);
			end
			else if (tok == "D") begin
				drive_record(fd);
			end
			else if (tok == "E") begin
				check_record(fd);
			end
			else if (tok == "R") begin
				code = $fscanf(fd, "%s %d", name, cycles);
				if (code != 2 || cycles < 1 || cycles > MAX_CYCLES) begin
					$display("Reset record %s is malformed", name);
					run_aborted = 1'b1;
				end
				else begin
					reset_dut(cycles);
				end
			end
			else begin
				$display("Unknown record type %s in the pattern file", tok);
				run_aborted = 1'b1;
			end
			code = $fscanf(fd, "%s", tok);
		end
		$fclose(fd);
	endtask

	initial begin
		void'($urandom(32'h9578));
		run_aborted  = 1'b0;
		expect_valid = 1'b0;
		expect_name  = '0;
		expect_data  = '0;
		reset_dut(10);
		run_patterns();
		$display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (!run_aborted && fail_count == 0 && pass_count > 0) begin
			$display("Regression passed");
		end
		else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- compile.f
logic/xbar_mon_pkg.sv
logic/bank_counter_array.sv
logic/chan_monitor.sv
logic/xbar_read_monitor.sv
test/xbar_read_monitor_checker.sv
test/xbar_read_monitor_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module xbar_read_monitor_tb \
	-f compile.f \
	-o xbar_read_monitor_sim

./obj_dir/xbar_read_monitor_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

if ! grep -q "Regression passed" sim.log; then
	echo "Simulation ended without a result, see sim.log"
	exit 1
fi

//--- test/xbar_patterns.txt
# D name cycles, then per channel 0 1 2: req_v acc op addr_hex rtn_v rtn_bank push_hex pop_hex
# E name ch bank outstanding occupancy err_bits(req_ovf rtn_unf rtn_unm rob_ovf rob_unf); R name cycles
E reset_c0_b0 0 0 0 0 00000
E reset_c1_b2 1 2 0 0 00000
E reset_c2_b3 2 3 0 0 00000
D rd_c0_b1 3 1 1 0 00000100 0 0 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0
D rd_c0_b2 1 1 1 0 0000A200 0 0 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0
D wr_c0_b1 2 1 1 1 00000100 0 0 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0
D noacc_c0_b1 2 1 0 0 00000100 0 0 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0
D rd_c1_b3 2 0 0 0 00000000 0 0 0 0  1 1 0 00000300 0 0 0 0  1 1 4 00000300 0 0 0 0
E rd_c0_b1 0 1 3 0 00000
E rd_c0_b2 0 2 1 0 00000
E rd_c0_b0 0 0 0 0 00000
E rd_c1_b3 1 3 2 0 00000
E inval_c2_b3 2 3 0 0 00000
D rtn_c0_b1 1 0 0 0 00000000 1 1 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0
D rtn_c1_b3 1 0 0 0 00000000 0 0 0 0  0 0 0 00000000 1 3 0 0  0 0 0 00000000 0 0 0 0
E rtn_c0_b1 0 1 2 0 00000
E rtn_c1_b3 1 3 1 0 00000
D mix_c0 1 1 1 0 00000200 1 1 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0
E mix_c0_b2 0 2 2 0 00000
E mix_c0_b1 0 1 1 0 00000
D same_c0_b2 1 1 1 0 00000200 1 2 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0
E same_c0_b2 0 2 2 0 00000
D push_c2_b0 3 0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 1 0
D push_c2_b2 3 0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 4 0
D pop_c2_b0 1 0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 1
D pushpop_c2_b2 2 0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 4 4
D push_c0_b1 2 0 0 0 00000000 0 0 2 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0
E rob_c2_b0 2 0 0 2 00000
E rob_c2_b2 2 2 0 3 00000
E rob_c2_b1 2 1 0 0 00000
E rob_c0_b1 0 1 1 2 00000
D unmatched_c1_b0 1 0 0 0 00000000 0 0 0 0  0 0 0 00000000 1 0 0 0  0 0 0 00000000 0 0 0 0
D rob_unf_c1_b2 1 0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 4  0 0 0 00000000 0 0 0 0
D idle_hold 5 0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0
E unmatched_c1_b0 1 0 0 0 01101
E unmatched_c1_b3 1 3 1 0 01101
E clean_c0_b0 0 0 0 0 00000
D ovf_fill_c2_b1 1023 0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0  1 1 0 00000100 0 0 0 0
E ovf_fill_c2_b1 2 1 1023 0 00000
D ovf_extra_c2_b1 1 0 0 0 00000000 0 0 0 0  0 0 0 00000000 0 0 0 0  1 1 0 00000100 0 0 0 0
E ovf_c2_b1 2 1 1023 0 10000
E sticky_c1_b0 1 0 0 0 01101
R reset_again 10
E rereset_c1_b0 1 0 0 0 00000
E rereset_c2_b1 2 1 0 0 00000
E rereset_c0_b1 0 1 0 0 00000
